// ==== Makefile ====
TOP = tb_soc_bus

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/100ps -f all.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "Simulation failed, see sim.log"; exit 1; fi
	@if ! grep -q "Result: PASSED" sim.log; then echo "No pass line in sim.log"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
hdl/soc_bus_pkg.sv
hdl/wb_grant_decode.sv
hdl/wb_ram_slave.sv
hdl/wb_response_mux.sv
hdl/soc_bus_top.sv
tb/tb_soc_bus.sv

// ==== hdl/soc_bus_pkg.sv ====
package soc_bus_pkg;

  // Bus population
  localparam int NR_MASTER = 2;  // Core data port and DMA port
  localparam int NR_SLAVE  = 4;  // Scratch RAM windows
  localparam int MST_W     = $clog2(NR_MASTER);

  // Classic Wishbone widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = DATA_W / 8;  // One enable per byte lane

  // Scratch RAM geometry
  localparam int SLAVE_WORDS = 64;
  localparam int OFFSET_W    = $clog2(SLAVE_WORDS);

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [SEL_W-1:0]  sel_t;

  // Address map, all windows are the same size and aligned to it
  localparam addr_t SLAVE_BASE [NR_SLAVE] = '{
    32'h0000_0000,
    32'h1000_0000,
    32'h1000_0100,  // Directly behind window 1
    32'h4000_0000
  };
  localparam int unsigned SLAVE_SIZE = 256;  // Bytes per window

  // Driven by one master for the whole bus cycle
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;  // Byte address
    data_t dat;
    sel_t  sel;
  } wb_req_t;

  // Returned to one master
  typedef struct packed {
    logic  ack;
    logic  err;
    data_t dat;
  } wb_rsp_t;

  // Broadcast to every RAM window, qualified there by its select bit
  typedef struct packed {
    logic                stb;
    logic                we;
    logic [OFFSET_W-1:0] offset;  // Word index inside the window
    data_t               dat;
    sel_t                sel;
  } slv_req_t;

  // State of the current bus cycle as seen by the response mux
  typedef struct packed {
    logic             valid;
    logic [MST_W-1:0] master;
    logic             hit;  // Address fell inside one of the windows
  } grant_t;

endpackage

// ==== hdl/soc_bus_top.sv ====
`timescale 1ns/100ps

module soc_bus_top (
  input  logic                  sys_clk,
  input  logic                  rst_n_i,
  input  soc_bus_pkg::wb_req_t  m_req_i [soc_bus_pkg::NR_MASTER],
  output soc_bus_pkg::wb_rsp_t  m_rsp_o [soc_bus_pkg::NR_MASTER]
);

  soc_bus_pkg::slv_req_t            slv_req;
  logic [soc_bus_pkg::NR_SLAVE-1:0] slv_sel;  // One-hot window select
  soc_bus_pkg::grant_t              grant;
  soc_bus_pkg::wb_rsp_t             s_rsp [soc_bus_pkg::NR_SLAVE];

  // Shared bus arbiter and address decoder
  wb_grant_decode wb_grant_decode_inst (
    .sys_clk   (sys_clk),
    .rst_n_i   (rst_n_i),
    .m_req_i   (m_req_i),
    .slv_req_o (slv_req),
    .slv_sel_o (slv_sel),
    .grant_o   (grant)
  );

  // Scratch RAM windows, one per map entry
  for (genvar k = 0; k < soc_bus_pkg::NR_SLAVE; k++) begin : g_ram
    wb_ram_slave wb_ram_slave_inst (
      .sys_clk   (sys_clk),
      .rst_n_i   (rst_n_i),
      .slv_req_i (slv_req),
      .sel_i     (slv_sel[k]),
      .rsp_o     (s_rsp[k])
    );
  end

  wb_response_mux wb_response_mux_inst (
    .sys_clk (sys_clk),
    .rst_n_i (rst_n_i),
    .s_rsp_i (s_rsp),
    .grant_i (grant),
    .m_rsp_o (m_rsp_o)  // Back to the granted master only
  );

endmodule

// ==== hdl/wb_grant_decode.sv ====
`timescale 1ns/100ps

module wb_grant_decode (
  input  logic                                sys_clk,
  input  logic                                rst_n_i,
  input  soc_bus_pkg::wb_req_t                m_req_i [soc_bus_pkg::NR_MASTER],
  output soc_bus_pkg::slv_req_t               slv_req_o,
  output logic [soc_bus_pkg::NR_SLAVE-1:0]    slv_sel_o,
  output soc_bus_pkg::grant_t                 grant_o
);

  logic                                 busy;
  logic                                 req_any;
  logic [soc_bus_pkg::MST_W-1:0]        pick;
  logic                                 nxt_valid;
  logic [soc_bus_pkg::MST_W-1:0]        nxt_mst;
  soc_bus_pkg::wb_req_t                 nxt_req;
  logic [soc_bus_pkg::NR_SLAVE-1:0]     hit_vec;
  logic                                 hit_any;

  // Registered slave side, stb is control and the rest is payload
  logic                                 stb_q;
  logic                                 we_q;
  logic [soc_bus_pkg::OFFSET_W-1:0]     offset_q;
  soc_bus_pkg::data_t                   dat_q;
  soc_bus_pkg::sel_t                    sel_q;

  // Current owner keeps the bus while its cyc stays up
  assign busy = grant_o.valid & m_req_i[grant_o.master].cyc;

  // Fixed priority, scanning downwards so the lowest index wins
  always_comb begin
    req_any = 1'b0;
    pick    = '0;
    for (int i = soc_bus_pkg::NR_MASTER - 1; i >= 0; i--) begin
      if (m_req_i[i].cyc && m_req_i[i].stb) begin
        req_any = 1'b1;
        pick    = soc_bus_pkg::MST_W'(i);
      end
    end
  end

  assign nxt_valid = busy | req_any;
  assign nxt_mst   = busy ? grant_o.master : pick;
  assign nxt_req   = m_req_i[nxt_mst];

  // Base and size compare per window, carried out in 33 bits
  always_comb begin
    for (int k = 0; k < soc_bus_pkg::NR_SLAVE; k++) begin
      hit_vec[k] = ({1'b0, nxt_req.adr} >= {1'b0, soc_bus_pkg::SLAVE_BASE[k]}) &&
                   ({1'b0, nxt_req.adr} < ({1'b0, soc_bus_pkg::SLAVE_BASE[k]} +
                                           33'(soc_bus_pkg::SLAVE_SIZE)));
    end
  end

  assign hit_any = |hit_vec;

  always_ff @(posedge sys_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      grant_o   <= '0;
      stb_q     <= 1'b0;
      slv_sel_o <= '0;
    end else begin
      grant_o.valid  <= nxt_valid;
      grant_o.master <= nxt_mst;
      grant_o.hit    <= nxt_valid & hit_any;
      // Master drops stb after ack, so the slave strobe follows one cycle later
      stb_q          <= nxt_valid & nxt_req.stb & hit_any;
      slv_sel_o      <= nxt_valid ? hit_vec : '0;
    end
  end

  always_ff @(posedge sys_clk) begin
    we_q     <= nxt_req.we;
    // Windows are aligned to their size, so the low address bits are the offset
    offset_q <= nxt_req.adr[soc_bus_pkg::OFFSET_W+1:2];
    dat_q    <= nxt_req.dat;
    sel_q    <= nxt_req.sel;
  end

  assign slv_req_o = '{
    stb:    stb_q,
    we:     we_q,
    offset: offset_q,
    dat:    dat_q,
    sel:    sel_q
  };

endmodule

// ==== hdl/wb_ram_slave.sv ====
`timescale 1ns/100ps

module wb_ram_slave (
  input  logic                   sys_clk,
  input  logic                   rst_n_i,
  input  soc_bus_pkg::slv_req_t  slv_req_i,
  input  logic                   sel_i,
  output soc_bus_pkg::wb_rsp_t   rsp_o
);

  soc_bus_pkg::data_t mem [soc_bus_pkg::SLAVE_WORDS];
  soc_bus_pkg::data_t rdata_q;
  logic               ack_q;
  logic               access;

  // One access per strobe, the cycle after ack is ignored
  assign access = slv_req_i.stb & sel_i & ~ack_q;

  always_ff @(posedge sys_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (access) begin
      if (slv_req_i.we) begin
        for (int b = 0; b < soc_bus_pkg::SEL_W; b++) begin
          if (slv_req_i.sel[b]) begin
            mem[slv_req_i.offset][b*8 +: 8] <= slv_req_i.dat[b*8 +: 8];  // Byte lane
          end
        end
      end
      rdata_q <= mem[slv_req_i.offset];  // Old word on a write
    end
  end

  // Data stays zero outside ack so the response OR stays clean
  assign rsp_o = '{
    ack: ack_q,
    err: 1'b0,
    dat: ack_q ? rdata_q : '0
  };

endmodule

// ==== hdl/wb_response_mux.sv ====
`timescale 1ns/100ps

module wb_response_mux (
  input  logic                  sys_clk,
  input  logic                  rst_n_i,
  input  soc_bus_pkg::wb_rsp_t  s_rsp_i [soc_bus_pkg::NR_SLAVE],
  input  soc_bus_pkg::grant_t   grant_i,
  output soc_bus_pkg::wb_rsp_t  m_rsp_o [soc_bus_pkg::NR_MASTER]
);

  logic               slv_ack;
  logic               slv_err;
  soc_bus_pkg::data_t slv_dat;
  logic               miss_err_q;

  // Only the selected window can answer, the others hold zeros
  always_comb begin
    slv_ack = 1'b0;
    slv_err = 1'b0;
    slv_dat = '0;
    for (int k = 0; k < soc_bus_pkg::NR_SLAVE; k++) begin
      slv_ack = slv_ack | s_rsp_i[k].ack;
      slv_err = slv_err | s_rsp_i[k].err;
      slv_dat = slv_dat | s_rsp_i[k].dat;
    end
  end

  // Decode miss answers with a single err pulse
  always_ff @(posedge sys_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      miss_err_q <= 1'b0;
    end else begin
      miss_err_q <= grant_i.valid & ~grant_i.hit & ~miss_err_q;
    end
  end

  always_comb begin
    for (int m = 0; m < soc_bus_pkg::NR_MASTER; m++) begin
      m_rsp_o[m] = '0;  // Losing masters see nothing
      if (grant_i.valid && (grant_i.master == soc_bus_pkg::MST_W'(m))) begin
        m_rsp_o[m].ack = slv_ack;
        m_rsp_o[m].err = slv_err | miss_err_q;
        m_rsp_o[m].dat = slv_dat;
      end
    end
  end

endmodule

// ==== tb/soc_bus_patterns.txt ====
// master we address wdata sel exp_rdata exp_err, all hex, one transaction per line
// exp_rdata is checked on reads that expect no err
// Master 0, core data port, windows 0 and 1
0 1 00000000 11223344 f 00000000 0
0 1 00000004 a5a5a5a5 f 00000000 0
0 0 00000000 00000000 f 11223344 0
0 1 10000000 cafef00d f 00000000 0
0 0 10000000 00000000 f cafef00d 0
0 1 00000000 0000ee00 2 00000000 0
0 0 00000000 00000000 f 1122ee44 0
0 1 00000004 77000066 9 00000000 0
0 0 00000004 00000000 f 77a5a566 0
0 0 20000000 00000000 f 00000000 1
0 1 100000fc 0badbeef f 00000000 0
0 0 100000fc 00000000 f 0badbeef 0
0 1 00000100 12345678 f 00000000 1
0 1 000000fc deadbeef f 00000000 0
0 0 000000fc 00000000 f deadbeef 0
0 1 10000000 00001234 3 00000000 0
0 0 10000000 00000000 f cafe1234 0
// Master 1, DMA port, windows 2 and 3
1 1 10000100 55aa55aa f 00000000 0
1 1 40000000 89abcdef f 00000000 0
1 0 10000100 00000000 f 55aa55aa 0
1 0 40000000 00000000 f 89abcdef 0
1 0 40000100 00000000 f 00000000 1
1 1 400000fc 01020304 f 00000000 0
1 1 40000000 00330000 4 00000000 0
1 0 40000000 00000000 f 8933cdef 0
1 0 400000fc 00000000 f 01020304 0
1 1 10000200 00000000 f 00000000 1
1 1 10000104 ffffffff f 00000000 0
1 1 10000104 00000000 c 00000000 0
1 0 10000104 00000000 f 0000ffff 0
1 0 10000100 00000000 f 55aa55aa 0

// ==== tb/tb_soc_bus.sv ====
`timescale 1ns/100ps

module tb_soc_bus;

  localparam int FIELDS  = 7;   // Tokens per transaction line
  localparam int MAX_PAT = 64;
  localparam int PERIOD  = 8;

  logic                 sys_clk = 1'b0;
  logic                 rst_n_i;
  soc_bus_pkg::wb_req_t m_req [soc_bus_pkg::NR_MASTER];
  soc_bus_pkg::wb_rsp_t m_rsp [soc_bus_pkg::NR_MASTER];

  logic [31:0]        pat_mem [FIELDS*MAX_PAT];
  int                 n_pat = 0;
  logic               loaded = 1'b0;
  int                 edge_cnt = 0;
  logic               own_valid = 1'b0;
  int                 owner = 0;
  int                 grant_edge [soc_bus_pkg::NR_MASTER];
  int                 first_done [soc_bus_pkg::NR_MASTER];
  logic [31:0]        rng_state  [soc_bus_pkg::NR_MASTER];
  soc_bus_pkg::data_t shadow [soc_bus_pkg::addr_t];  // Expected memory contents by byte address

  soc_bus_top soc_bus_top_inst (
    .sys_clk (sys_clk),
    .rst_n_i (rst_n_i),
    .m_req_i (m_req),
    .m_rsp_o (m_rsp)
  );

  always #(PERIOD/2) sys_clk = ~sys_clk;

  // Expected arbitration: free bus goes to the lowest requesting index,
  // the owner keeps it while its cyc stays high
  always @(posedge sys_clk) begin
    edge_cnt = edge_cnt + 1;
    if (!(own_valid && m_req[owner].cyc)) begin
      own_valid = 1'b0;
      for (int m = soc_bus_pkg::NR_MASTER - 1; m >= 0; m--) begin
        if (m_req[m].cyc && m_req[m].stb) begin
          own_valid = 1'b1;
          owner     = m;
        end
      end
      if (own_valid) begin
        grant_edge[owner] = edge_cnt;  // Response due one edge later
      end
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Old word with the enabled byte lanes replaced
  function automatic soc_bus_pkg::data_t merge_bytes(input soc_bus_pkg::data_t old_w,
                                                     input soc_bus_pkg::data_t new_w,
                                                     input soc_bus_pkg::sel_t  sel);
    soc_bus_pkg::data_t w;
    w = old_w;
    for (int b = 0; b < soc_bus_pkg::SEL_W; b++) begin
      if (sel[b]) begin
        w[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return w;
  endfunction

  task automatic stop_on_error();
    $display("Result: FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_rdata(input string name, input soc_bus_pkg::data_t got,
                             input soc_bus_pkg::data_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_ack(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_on_error();
    end
  endtask

  // Plays every pattern line that belongs to master m, in file order
  task automatic run_master(input int m);
    int                 idx [$];
    int                 gap;
    int                 base;
    int                 launch;
    int                 done;
    logic               we;
    soc_bus_pkg::addr_t adr;
    soc_bus_pkg::data_t wdat;
    soc_bus_pkg::sel_t  sel;
    soc_bus_pkg::data_t exp_dat;
    logic               exp_err;
    soc_bus_pkg::data_t model_dat;
    string              tag;
    for (int i = 0; i < n_pat; i++) begin
      if (pat_mem[i*FIELDS] == 32'(m)) begin
        idx.push_back(i);
      end
    end
    foreach (idx[j]) begin
      if (j > 0) begin
        rng_state[m] = xorshift32(rng_state[m]);
        gap = int'(rng_state[m] % 4);  // Extra idle cycles, 0 to 3
        repeat (gap) @(posedge sys_clk);
      end
      base    = idx[j] * FIELDS;
      we      = pat_mem[base+1][0];
      adr     = pat_mem[base+2];
      wdat    = pat_mem[base+3];
      sel     = pat_mem[base+4][soc_bus_pkg::SEL_W-1:0];
      exp_dat = pat_mem[base+5];
      exp_err = pat_mem[base+6][0];
      tag     = $sformatf("m_rsp[%0d] line %0d", m, idx[j]);
      @(posedge sys_clk);
      #1;
      m_req[m] = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat, sel: sel};
      launch   = edge_cnt;
      do begin
        @(posedge sys_clk);
        #1;
      end while (!(m_rsp[m].ack === 1'b1 || m_rsp[m].err === 1'b1));
      done = edge_cnt;
      check_ack({tag, " ack"}, m_rsp[m].ack, ~exp_err);
      check_err({tag, " err"}, m_rsp[m].err, exp_err);
      // Two edges on an idle bus, later when the other master holds it
      check_cycles({tag, " latency"}, done - launch, grant_edge[m] - launch + 1);
      if (shadow.exists(adr)) begin
        model_dat = shadow[adr];
      end else begin
        model_dat = 'x;
      end
      if (!exp_err && !we) begin
        check_rdata({tag, " dat"}, m_rsp[m].dat, exp_dat);
        check_rdata({tag, " dat vs lane model"}, m_rsp[m].dat, model_dat);
      end
      if (!exp_err && we) begin
        shadow[adr] = merge_bytes(model_dat, wdat, sel);
      end
      m_req[m] = '0;  // Idle for at least one edge
      if (j == 0) begin
        first_done[m] = done;
      end
    end
  endtask

  // Watchdog, sized from the number of transactions
  initial begin
    wait (loaded);
    #(n_pat * 20 * PERIOD);
    $display("Timeout: %0d bus transactions did not finish within %0d ns",
             n_pat, n_pat * 20 * PERIOD);
    stop_on_error();
  end

  initial begin
    rst_n_i = 1'b0;
    for (int m = 0; m < soc_bus_pkg::NR_MASTER; m++) begin
      m_req[m]      = '0;
      grant_edge[m] = 0;
      first_done[m] = 0;
    end
    rng_state[0] = 32'd83591;
    rng_state[1] = xorshift32(32'd83591);  // Separate stream for the DMA port
    for (int i = 0; i < FIELDS * MAX_PAT; i++) begin
      pat_mem[i] = 32'hF000_0000 | 32'(i);  // No valid master index
    end
    $readmemh("tb/soc_bus_patterns.txt", pat_mem);
    while (n_pat < MAX_PAT && pat_mem[n_pat*FIELDS] < 32'(soc_bus_pkg::NR_MASTER)) begin
      n_pat++;
    end
    if (n_pat == 0) begin
      $display("The pattern file holds no transactions");
      stop_on_error();
    end
    loaded = 1'b1;
    repeat (3) @(posedge sys_clk);
    #1;
    rst_n_i = 1'b1;
    fork
      run_master(0);
      run_master(1);
    join
    // Both first requests go out on the same edge
    if (first_done[0] >= first_done[1]) begin
      $display("Master 0 should finish before master 1 when both request together");
      stop_on_error();
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule
